//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic por
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	// power-on reset, two rising edges
	initial begin
		por = 1'b1;
		repeat (2) @(posedge clk);
		por <= 1'b0;
	end

endmodule

//--- bench/mips_tb.sv
`timescale 1ns/1ps

module mips_tb;

	localparam int IMEM_WORDS = 128;
	localparam int DMEM_WORDS = 128;
	localparam int NUM_PROGS  = 7;
	localparam int MAX_LEN    = 32;
	localparam int LIMIT      = 40 * MAX_LEN * NUM_PROGS;   // cycles for the whole run

	logic clk;
	logic por;
	logic rst_req;
	logic reset;
	logic debug_hold;
	logic inst_we;
	mips_pkg::data_t inst_addr;
	mips_pkg::data_t inst_wdata;
	logic debug_ram_sel;
	mips_pkg::data_t dbg_ram_addr;
	mips_pkg::reg_idx_t dbg_reg_addr;
	mips_pkg::data_t pc;
	mips_pkg::data_t dbg_reg_data;
	mips_pkg::data_t dbg_ram_data;
	logic halt_flag;

	mips_pkg::data_t prog [$];
	mips_pkg::data_t exp_regs [32];
	mips_pkg::data_t exp_mem [DMEM_WORDS];
	bit touched [DMEM_WORDS];   // words stored by any program so far
	bit stored [16];            // random programs load only from these
	logic [15:0] lfsr;
	mips_pkg::data_t pc_halt;
	logic cmp_reg;
	logic cmp_ram;
	logic cmp_halt;
	int cycles;

	assign reset = por | rst_req;

	clock_gen u_clk (.clk(clk), .por(por));

	mips_top #(
		.IMEM_DEPTH(IMEM_WORDS),
		.DMEM_DEPTH(DMEM_WORDS)
	) DUT (
		.clk(clk), .reset(reset),
		.debug_hold(debug_hold), .inst_we(inst_we),
		.inst_addr(inst_addr), .inst_wdata(inst_wdata),
		.debug_ram_sel(debug_ram_sel), .dbg_ram_addr(dbg_ram_addr),
		.dbg_reg_addr(dbg_reg_addr),
		.pc(pc), .dbg_reg_data(dbg_reg_data), .dbg_ram_data(dbg_ram_data),
		.halt_flag(halt_flag)
	);

	task automatic check_data(input string name, input mips_pkg::data_t got,
		input mips_pkg::data_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// galois lfsr, one step per bit
	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic mips_pkg::data_t enc_r(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic mips_pkg::data_t enc_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model, one instruction at a time
	////////////////////////////////////////////////////////////////////////////

	function automatic void run_reference();
		int ip;
		int steps;
		int idx;
		mips_pkg::data_t w;
		mips_pkg::data_t a;
		mips_pkg::data_t b;
		mips_pkg::data_t imm;
		mips_pkg::data_t res;
		logic [4:0] dst;
		logic wr;
		logic done;
		for (int i = 0; i < 32; i++)
			exp_regs[i] = '0;   // core reset clears the register file
		ip = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 1000 && ip < prog.size()) begin
			w = prog[ip];
			a = exp_regs[w[25:21]];
			b = exp_regs[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			idx = int'((a + imm) >> 2) % DMEM_WORDS;
			wr = 1'b0;
			dst = w[20:16];
			res = '0;
			ip = ip + 1;
			steps = steps + 1;
			if (w == 32'hffff_ffff) begin
				done = 1'b1;
			end else begin
				case (w[31:26])
					mips_pkg::OP_RTYPE: begin
						dst = w[15:11];
						wr = 1'b1;
						case (w[5:0])
							mips_pkg::FN_ADD: res = a + b;
							mips_pkg::FN_SUB: res = a - b;
							mips_pkg::FN_AND: res = a & b;
							mips_pkg::FN_OR:  res = a | b;
							mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
							default: wr = 1'b0;
						endcase
					end
					mips_pkg::OP_ADDI: begin
						res = a + imm;
						wr = 1'b1;
					end
					mips_pkg::OP_LW: begin
						res = exp_mem[idx];
						wr = 1'b1;
					end
					mips_pkg::OP_SW: begin
						exp_mem[idx] = b;
						touched[idx] = 1'b1;
					end
					mips_pkg::OP_BEQ: if (a == b) ip = ip + int'($signed(imm));
					mips_pkg::OP_J:   ip = int'(w[25:0]);
					default: ;
				endcase
				if (wr && dst != 5'd0)
					exp_regs[dst] = res;
			end
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// programs
	////////////////////////////////////////////////////////////////////////////

	task automatic build_alu_prog();
		prog.delete();
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd1, 16'hfffd));
		prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd3, 5'd2, 5'd1));
		prog.push_back(enc_r(mips_pkg::FN_SUB, 5'd4, 5'd3, 5'd2));
		prog.push_back(enc_r(mips_pkg::FN_AND, 5'd5, 5'd4, 5'd3));
		prog.push_back(enc_r(mips_pkg::FN_OR, 5'd6, 5'd5, 5'd2));
		prog.push_back(enc_r(mips_pkg::FN_SLT, 5'd7, 5'd2, 5'd6));
		prog.push_back(enc_r(mips_pkg::FN_SLT, 5'd8, 5'd6, 5'd2));
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd0, 5'd7, 16'd99));   // r0 stays zero
		prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd0, 5'd3, 5'd3));
		prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd9, 5'd0, 5'd7));
		prog.push_back(enc_r(mips_pkg::FN_SUB, 5'd10, 5'd0, 5'd6));
		prog.push_back(enc_r(mips_pkg::FN_SLT, 5'd11, 5'd10, 5'd9));
		prog.push_back(mips_pkg::HALT_WORD);
	endtask

	task automatic build_mem_prog();
		prog.delete();
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd64));   // word 16
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'h1234));
		prog.push_back(enc_i(mips_pkg::OP_SW, 5'd2, 5'd1, 16'd0));
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'hffec));
		prog.push_back(enc_i(mips_pkg::OP_SW, 5'd3, 5'd1, 16'd4));
		prog.push_back(enc_i(mips_pkg::OP_LW, 5'd4, 5'd1, 16'd0));
		prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd5, 5'd4, 5'd4));      // load-use
		prog.push_back(enc_i(mips_pkg::OP_LW, 5'd6, 5'd1, 16'd4));
		prog.push_back(enc_i(mips_pkg::OP_SW, 5'd6, 5'd1, 16'd8));      // store of a fresh load
		prog.push_back(enc_i(mips_pkg::OP_LW, 5'd7, 5'd1, 16'd8));
		prog.push_back(enc_r(mips_pkg::FN_SUB, 5'd8, 5'd7, 5'd5));
		prog.push_back(mips_pkg::HALT_WORD);
	endtask

	task automatic build_branch_prog();
		prog.delete();
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'd3));
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd2, 5'd0, 16'd3));
		prog.push_back(enc_i(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd3));     // taken, to word 6
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd3, 5'd0, 16'd111));
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd4, 5'd0, 16'd222));
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd12, 5'd0, 16'd333)); // third word in flight
		prog.push_back(enc_i(mips_pkg::OP_BEQ, 5'd0, 5'd2, 16'd1));     // not taken
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd5, 5'd0, 16'd55));
		prog.push_back({mips_pkg::OP_J, 26'd11});
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd6, 5'd0, 16'd66));
		prog.push_back(enc_i(mips_pkg::OP_ADDI, 5'd7, 5'd0, 16'd77));
		prog.push_back(enc_r(mips_pkg::FN_ADD, 5'd8, 5'd5, 5'd1));
		prog.push_back(mips_pkg::HALT_WORD);
	endtask

	// 24 alu and memory words on r0..r7, addresses in words 0..15
	task automatic build_random_prog();
		int unsigned kind;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [3:0] slot;
		prog.delete();
		for (int n = 0; n < 24; n++) begin
			kind = rand_bits(3);
			rd = 5'(rand_bits(3));
			rs = 5'(rand_bits(3));
			rt = 5'(rand_bits(3));
			case (kind)
				0: prog.push_back(enc_r(mips_pkg::FN_ADD, rd, rs, rt));
				1: prog.push_back(enc_r(mips_pkg::FN_SUB, rd, rs, rt));
				2: prog.push_back(enc_r(mips_pkg::FN_AND, rd, rs, rt));
				3: prog.push_back(enc_r(mips_pkg::FN_OR, rd, rs, rt));
				4: prog.push_back(enc_r(mips_pkg::FN_SLT, rd, rs, rt));
				5: prog.push_back(enc_i(mips_pkg::OP_ADDI, rd, rs, 16'(rand_bits(16))));
				default: begin
					slot = 4'(rand_bits(4));
					if (kind == 6 && stored[slot]) begin
						prog.push_back(enc_i(mips_pkg::OP_LW, rd, 5'd0, {10'd0, slot, 2'b00}));
					end else begin
						prog.push_back(enc_i(mips_pkg::OP_SW, rt, 5'd0, {10'd0, slot, 2'b00}));
						stored[slot] = 1'b1;
					end
				end
			endcase
		end
		prog.push_back(mips_pkg::HALT_WORD);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// load, run, read back
	////////////////////////////////////////////////////////////////////////////

	task automatic run_program();
		run_reference();
		@(posedge clk);
		rst_req <= 1'b1;
		debug_hold <= 1'b1;
		debug_ram_sel <= 1'b0;
		for (int i = 0; i < prog.size() + 6; i++) begin   // halt words past the end for prefetch
			@(posedge clk);
			inst_we <= 1'b1;
			inst_addr <= i * 4;
			inst_wdata <= (i < prog.size()) ? prog[i] : mips_pkg::HALT_WORD;
		end
		@(posedge clk);
		inst_we <= 1'b0;
		rst_req <= 1'b0;
		@(posedge clk);
		debug_hold <= 1'b0;
		do
			@(negedge clk);
		while (halt_flag !== 1'b1);
		pc_halt = pc;
		@(posedge clk);
		cmp_halt <= 1'b1;
		repeat (20) @(posedge clk);
		cmp_halt <= 1'b0;
		for (int r = 0; r < 32; r++) begin
			dbg_reg_addr <= 5'(r);
			cmp_reg <= 1'b1;
			@(posedge clk);
		end
		cmp_reg <= 1'b0;
		debug_ram_sel <= 1'b1;
		for (int m = 0; m < DMEM_WORDS; m++) begin
			if (touched[m]) begin
				dbg_ram_addr <= m * 4;
				cmp_ram <= 1'b1;
				@(posedge clk);
			end
		end
		cmp_ram <= 1'b0;
		debug_ram_sel <= 1'b0;
	endtask

	// compares the debug ports against the reference between edges
	always @(negedge clk) begin
		if (DUT.u_sva.fail_count != 0) begin
			$display("a concurrent assertion on the DUT failed, see the error above");
			$display("tests failed");
			$fatal(1, "assertion failure");
		end
		if (cmp_reg)
			check_data($sformatf("dbg_reg_data r%0d", dbg_reg_addr), dbg_reg_data,
				exp_regs[dbg_reg_addr]);
		if (cmp_ram)
			check_data($sformatf("dbg_ram_data @%h", dbg_ram_addr), dbg_ram_data,
				exp_mem[int'(dbg_ram_addr >> 2) % DMEM_WORDS]);
		if (cmp_halt) begin
			check_flag("halt_flag", halt_flag, 1'b1);
			check_data("pc", pc, pc_halt);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout, the run did not finish within %0d cycles", LIMIT);
			$display("tests failed");
			$fatal(1, "run aborted");
		end
	end

	initial begin
		rst_req = 1'b1;
		debug_hold = 1'b1;
		inst_we = 1'b0;
		inst_addr = '0;
		inst_wdata = '0;
		debug_ram_sel = 1'b0;
		dbg_ram_addr = '0;
		dbg_reg_addr = '0;
		cmp_reg = 1'b0;
		cmp_ram = 1'b0;
		cmp_halt = 1'b0;
		cycles = 0;
		lfsr = 16'd6;
		build_alu_prog();
		run_program();
		build_mem_prog();
		run_program();
		build_branch_prog();
		run_program();
		repeat (NUM_PROGS - 3) begin
			build_random_prog();
			run_program();
		end
		if (DUT.u_sva.fail_count != 0) begin
			$display("a concurrent assertion on the DUT failed, see the error above");
			$display("tests failed");
			$fatal(1, "assertion failure");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- bench/mips_tb_sva.sv
`timescale 1ns/1ps

module mips_tb_sva (
	input logic            clk,
	input logic            reset,
	input logic            halt_flag,
	input logic            debug_hold,
	input mips_pkg::data_t pc
);

	int unsigned fail_count = 0;   // failed assertions so far

	// sticky until a reset is seen
	halt_sticky: assert property (@(posedge clk) halt_flag && !reset |=> halt_flag)
		else begin
			fail_count++;
			$error("halt_flag dropped without reset");
		end

	halt_pc_frozen: assert property (@(posedge clk) halt_flag && !reset |=> pc == $past(pc))
		else begin
			fail_count++;
			$error("pc moved while halted");
		end

	// loader window, pc must not move
	hold_pc_frozen: assert property (@(posedge clk) debug_hold && !reset |=> pc == $past(pc))
		else begin
			fail_count++;
			$error("pc moved while debug_hold was high");
		end

endmodule

bind mips_top mips_tb_sva u_sva (
	.clk(clk),
	.reset(reset),
	.halt_flag(halt_flag),
	.debug_hold(debug_hold),
	.pc(pc)
);

//--- run_sim.sh
#!/bin/sh
# build and run the mips testbench with verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module mips_tb -f verilog.f -o mips_sim
./obj_dir/mips_sim 2>&1 | tee sim.log

if grep -q "^all tests passed$" sim.log; then
	exit 0
fi
echo "simulation did not report success, see sim.log"
exit 1

//--- src/mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
	input  logic               clk,
	input  logic               reset,
	input  mips_pkg::if_id_t   if_id,
	input  logic               flush,
	input  logic               wb_write,
	input  mips_pkg::reg_idx_t wb_reg,
	input  mips_pkg::data_t    wb_data,
	input  mips_pkg::reg_idx_t dbg_reg_addr,
	output mips_pkg::data_t    dbg_reg_data,
	output logic               stall,
	output logic               jump_take,
	output mips_pkg::data_t    jump_target,
	output mips_pkg::id_ex_t   id_ex
);

	mips_pkg::data_t     regs [32];
	mips_pkg::instr_u    instr;
	mips_pkg::ex_ctrl_t  ex_c;
	mips_pkg::mem_ctrl_t mem_c;
	mips_pkg::wb_ctrl_t  wb_c;
	mips_pkg::data_t     reg1;
	mips_pkg::data_t     reg2;
	logic                uses_rs;
	logic                uses_rt;
	logic                is_jump;
	logic                is_halt;
	logic                issue;
	logic                halt_seen;   // halt went down, younger words are dropped

	// r0 reads zero, a write in the same cycle is bypassed
	function automatic mips_pkg::data_t rf_read(input mips_pkg::reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (wb_write && wb_reg == idx)
			return wb_data;
		return regs[idx];
	endfunction

	assign instr = if_id.instr;

	always_comb begin
		reg1         = rf_read(instr.r_fmt.rs);
		reg2         = rf_read(instr.r_fmt.rt);
		dbg_reg_data = rf_read(dbg_reg_addr);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_write && wb_reg != '0) begin
			regs[wb_reg] <= wb_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ex_c    = '0;
		mem_c   = '0;
		wb_c    = '0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		is_jump = 1'b0;
		is_halt = 1'b0;
		case (instr.r_fmt.opcode)
			mips_pkg::OP_RTYPE: begin
				ex_c.reg_dst_rd = 1'b1;
				wb_c.reg_write  = 1'b1;
				uses_rs         = 1'b1;
				uses_rt         = 1'b1;
				case (instr.r_fmt.funct)
					mips_pkg::FN_ADD: ex_c.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: ex_c.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: ex_c.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  ex_c.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: ex_c.alu_op = mips_pkg::ALU_SLT;
					default: wb_c.reg_write = 1'b0;   // unknown funct is a nop
				endcase
			end
			mips_pkg::OP_ADDI: begin
				ex_c.alu_src_imm = 1'b1;
				wb_c.reg_write   = 1'b1;
				uses_rs          = 1'b1;
			end
			mips_pkg::OP_LW: begin
				ex_c.alu_src_imm = 1'b1;
				mem_c.mem_read   = 1'b1;
				wb_c.reg_write   = 1'b1;
				wb_c.mem_to_reg  = 1'b1;
				uses_rs          = 1'b1;
			end
			mips_pkg::OP_SW: begin
				ex_c.alu_src_imm = 1'b1;
				mem_c.mem_write  = 1'b1;
				uses_rs          = 1'b1;
				uses_rt          = 1'b1;
			end
			mips_pkg::OP_BEQ: begin
				ex_c.alu_op  = mips_pkg::ALU_SUB;   // zero flag decides
				mem_c.branch = 1'b1;
				uses_rs      = 1'b1;
				uses_rt      = 1'b1;
			end
			mips_pkg::OP_J:    is_jump = 1'b1;
			mips_pkg::OP_HALT: is_halt = (instr == mips_pkg::HALT_WORD);
			default: ;
		endcase
	end

	// load in ex whose rt is read here
	assign stall = if_id.valid && id_ex.mem.mem_read && id_ex.rt != '0 &&
		((uses_rs && id_ex.rt == instr.r_fmt.rs) || (uses_rt && id_ex.rt == instr.r_fmt.rt));

	assign issue       = if_id.valid && !flush && !stall && !halt_seen;
	assign jump_take   = issue && is_jump;
	assign jump_target = {if_id.pc_plus4[31:28], instr.i_fmt.rs, instr.i_fmt.rt,
		instr.i_fmt.imm, 2'b00};

	always_ff @(posedge clk) begin
		if (reset || flush)
			halt_seen <= 1'b0;
		else if (issue && is_halt)
			halt_seen <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset || !issue) begin
			id_ex <= '0;    // bubble
		end else begin
			id_ex.ex       <= ex_c;
			id_ex.mem      <= mem_c;
			id_ex.wb       <= wb_c;
			id_ex.pc_plus4 <= if_id.pc_plus4;
			id_ex.reg1     <= reg1;
			id_ex.reg2     <= reg2;
			id_ex.sign_ext <= {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
			id_ex.rs       <= instr.r_fmt.rs;
			id_ex.rt       <= instr.r_fmt.rt;
			id_ex.rd       <= instr.r_fmt.rd;
			id_ex.halt     <= is_halt;
		end
	end

endmodule

//--- src/mips_execute.sv
`timescale 1ns/1ps

module mips_execute (
	input  logic               clk,
	input  logic               reset,
	input  mips_pkg::id_ex_t   id_ex,
	input  logic               flush,
	input  mips_pkg::ex_mem_t  mem_fwd,
	input  logic               wb_write,
	input  mips_pkg::reg_idx_t wb_reg,
	input  mips_pkg::data_t    wb_data,
	output mips_pkg::ex_mem_t  ex_mem
);

	mips_pkg::data_t op_a;
	mips_pkg::data_t op_b;
	mips_pkg::data_t rt_val;
	mips_pkg::data_t alu_out;

	// youngest producer wins, mem stage before wb stage
	function automatic mips_pkg::data_t forward(
		input mips_pkg::reg_idx_t src,
		input mips_pkg::data_t    reg_val,
		input mips_pkg::ex_mem_t  mem_st,
		input logic               wb_we,
		input mips_pkg::reg_idx_t wb_dst,
		input mips_pkg::data_t    wb_val
	);
		if (src == '0)
			return '0;
		if (mem_st.wb.reg_write && mem_st.write_reg == src)
			return mem_st.alu_out;   // never a load here, decode stalls those
		if (wb_we && wb_dst == src)
			return wb_val;
		return reg_val;
	endfunction

	assign op_a   = forward(id_ex.rs, id_ex.reg1, mem_fwd, wb_write, wb_reg, wb_data);
	assign rt_val = forward(id_ex.rt, id_ex.reg2, mem_fwd, wb_write, wb_reg, wb_data);
	assign op_b   = id_ex.ex.alu_src_imm ? id_ex.sign_ext : rt_val;

	////////////////////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (id_ex.ex.alu_op)
			mips_pkg::ALU_ADD: alu_out = op_a + op_b;
			mips_pkg::ALU_SUB: alu_out = op_a - op_b;
			mips_pkg::ALU_AND: alu_out = op_a & op_b;
			mips_pkg::ALU_OR:  alu_out = op_a | op_b;
			mips_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			default:           alu_out = '0;
		endcase
	end

	// a taken branch in mem kills the word sitting here
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			ex_mem <= '0;
		end else begin
			ex_mem.mem           <= id_ex.mem;
			ex_mem.wb            <= id_ex.wb;
			ex_mem.branch_target <= id_ex.pc_plus4 + {id_ex.sign_ext[29:0], 2'b00};
			ex_mem.zero          <= (alu_out == '0);
			ex_mem.alu_out       <= alu_out;
			ex_mem.store_data    <= rt_val;
			ex_mem.write_reg     <= id_ex.ex.reg_dst_rd ? id_ex.rd : id_ex.rt;
			ex_mem.halt          <= id_ex.halt;
		end
	end

endmodule

//--- src/mips_fetch.sv
`timescale 1ns/1ps

module mips_fetch #(
	parameter int IMEM_DEPTH = 128
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             debug_hold,
	input  logic             inst_we,
	input  mips_pkg::data_t  inst_addr,    // byte address, word aligned
	input  mips_pkg::data_t  inst_wdata,
	input  logic             stall,
	input  logic             jump_take,
	input  mips_pkg::data_t  jump_target,
	input  logic             pc_take,
	input  mips_pkg::data_t  pc_target,
	input  logic             halted,
	output mips_pkg::if_id_t if_id,
	output mips_pkg::data_t  pc
);

	localparam int IAW = $clog2(IMEM_DEPTH);

	mips_pkg::data_t  imem [IMEM_DEPTH];
	mips_pkg::data_t  pc_plus4;
	mips_pkg::instr_u fetched;

	assign pc_plus4 = pc + 32'd4;
	assign fetched  = imem[pc[IAW+1:2]];   // async read

	// program loader, only while the core is held
	always_ff @(posedge clk) begin
		if (debug_hold && inst_we)
			imem[inst_addr[IAW+1:2]] <= inst_wdata;
	end

	////////////////////////////////////////////////////////////////////////////
	// next pc, branch beats jump beats pc+4
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pc          <= '0;
			if_id.valid <= 1'b0;
		end else if (halted || debug_hold) begin
			if_id.valid <= 1'b0;       // pc frozen, only bubbles go down
		end else if (pc_take) begin
			pc          <= pc_target;
			if_id.valid <= 1'b0;       // flush the fetched word
		end else if (stall) begin
			// load-use, keep pc and if/id as they are
		end else if (jump_take) begin
			pc          <= jump_target;
			if_id.valid <= 1'b0;
		end else begin
			pc             <= pc_plus4;
			if_id.pc_plus4 <= pc_plus4;
			if_id.instr    <= fetched;
			if_id.valid    <= 1'b1;
		end
	end

endmodule

//--- src/mips_memory.sv
`timescale 1ns/1ps

module mips_memory #(
	parameter int DMEM_DEPTH = 128
) (
	input  logic               clk,
	input  logic               reset,
	input  mips_pkg::ex_mem_t  ex_mem,
	input  logic               debug_ram_sel,
	input  mips_pkg::data_t    dbg_ram_addr,   // byte address
	output mips_pkg::data_t    dbg_ram_data,
	output logic               pc_take,
	output mips_pkg::data_t    pc_target,
	output logic               wb_write,
	output mips_pkg::reg_idx_t wb_reg,
	output mips_pkg::data_t    wb_data,
	output logic               halted
);

	localparam int DAW = $clog2(DMEM_DEPTH);

	mips_pkg::data_t   dmem [DMEM_DEPTH];
	mips_pkg::data_t   rd_addr;
	mips_pkg::data_t   rd_word;
	mips_pkg::mem_wb_t mem_wb;
	logic              halt_q;

	// debug read borrows the load port
	assign rd_addr      = debug_ram_sel ? dbg_ram_addr : ex_mem.alu_out;
	assign rd_word      = dmem[rd_addr[DAW+1:2]];
	assign dbg_ram_data = rd_word;

	always_ff @(posedge clk) begin
		if (ex_mem.mem.mem_write)
			dmem[ex_mem.alu_out[DAW+1:2]] <= ex_mem.store_data;
	end

	assign pc_take   = ex_mem.mem.branch && ex_mem.zero;   // beq resolved here
	assign pc_target = ex_mem.branch_target;

	////////////////////////////////////////////////////////////////////////////
	// mem/wb and write back
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb <= '0;
		end else begin
			mem_wb.wb        <= ex_mem.wb;
			mem_wb.read_data <= rd_word;
			mem_wb.alu_out   <= ex_mem.alu_out;
			mem_wb.write_reg <= ex_mem.write_reg;
			mem_wb.halt      <= ex_mem.halt;
		end
	end

	assign wb_write = mem_wb.wb.reg_write;
	assign wb_reg   = mem_wb.write_reg;
	assign wb_data  = mem_wb.wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_out;

	// sticky until reset
	always_ff @(posedge clk) begin
		if (reset)
			halt_q <= 1'b0;
		else if (mem_wb.halt)
			halt_q <= 1'b1;
	end

	assign halted = mem_wb.halt || halt_q;

endmodule

//--- src/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] data_t;
	typedef logic [4:0]  reg_idx_t;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = 6'h3f
	} opcode_e;

	// funct codes, register format only
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;   // j target uses rs, rt and imm together
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    reg_dst_rd;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic branch;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	//////////////////////////////////////////////////////////////////////////
	// pipeline registers
	//////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		data_t  pc_plus4;
		instr_u instr;
		logic   valid;
	} if_id_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
		data_t     pc_plus4;
		data_t     reg1;
		data_t     reg2;
		data_t     sign_ext;
		reg_idx_t  rs;
		reg_idx_t  rt;
		reg_idx_t  rd;
		logic      halt;
	} id_ex_t;

	typedef struct packed {
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
		data_t     branch_target;
		logic      zero;
		data_t     alu_out;
		data_t     store_data;
		reg_idx_t  write_reg;
		logic      halt;
	} ex_mem_t;

	typedef struct packed {
		wb_ctrl_t wb;
		data_t    read_data;
		data_t    alu_out;
		reg_idx_t write_reg;
		logic     halt;
	} mem_wb_t;

	localparam data_t HALT_WORD = 32'hffff_ffff;

endpackage

//--- src/mips_top.sv
`timescale 1ns/1ps

module mips_top #(
	parameter int IMEM_DEPTH = 128,
	parameter int DMEM_DEPTH = 128
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               debug_hold,
	input  logic               inst_we,
	input  mips_pkg::data_t    inst_addr,
	input  mips_pkg::data_t    inst_wdata,
	input  logic               debug_ram_sel,
	input  mips_pkg::data_t    dbg_ram_addr,
	input  mips_pkg::reg_idx_t dbg_reg_addr,
	output mips_pkg::data_t    pc,
	output mips_pkg::data_t    dbg_reg_data,
	output mips_pkg::data_t    dbg_ram_data,
	output logic               halt_flag
);

	mips_pkg::if_id_t   if_id;
	mips_pkg::id_ex_t   id_ex;
	mips_pkg::ex_mem_t  ex_mem;

	logic               stall;
	logic               jump_take;
	mips_pkg::data_t    jump_target;
	logic               pc_take;      // also the flush for if/id, id/ex, ex/mem
	mips_pkg::data_t    pc_target;

	// write back, fed to decode and to forwarding
	logic               wb_write;
	mips_pkg::reg_idx_t wb_reg;
	mips_pkg::data_t    wb_data;

	////////////////////////////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////////////////////////////

	mips_fetch #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) u_fetch (
		.clk(clk), .reset(reset),
		.debug_hold(debug_hold), .inst_we(inst_we),
		.inst_addr(inst_addr), .inst_wdata(inst_wdata),
		.stall(stall), .jump_take(jump_take), .jump_target(jump_target),
		.pc_take(pc_take), .pc_target(pc_target), .halted(halt_flag),
		.if_id(if_id), .pc(pc)
	);

	mips_decode u_decode (
		.clk(clk), .reset(reset),
		.if_id(if_id), .flush(pc_take),
		.wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data),
		.dbg_reg_addr(dbg_reg_addr), .dbg_reg_data(dbg_reg_data),
		.stall(stall), .jump_take(jump_take), .jump_target(jump_target),
		.id_ex(id_ex)
	);

	mips_execute u_execute (
		.clk(clk), .reset(reset),
		.id_ex(id_ex), .flush(pc_take),
		.mem_fwd(ex_mem),                // own output, seen by the mem stage
		.wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data),
		.ex_mem(ex_mem)
	);

	mips_memory #(
		.DMEM_DEPTH(DMEM_DEPTH)
	) u_memory (
		.clk(clk), .reset(reset),
		.ex_mem(ex_mem),
		.debug_ram_sel(debug_ram_sel), .dbg_ram_addr(dbg_ram_addr),
		.dbg_ram_data(dbg_ram_data),
		.pc_take(pc_take), .pc_target(pc_target),
		.wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data),
		.halted(halt_flag)
	);

endmodule

//--- verilog.f
src/mips_pkg.sv
src/mips_fetch.sv
src/mips_decode.sv
src/mips_execute.sv
src/mips_memory.sv
src/mips_top.sv
bench/clock_gen.sv
bench/mips_tb_sva.sv
bench/mips_tb.sv
